// File: dv/processorTb.sv
//--------------------------------------------------------------------
// Directed testbench for the register-bus core. Each test drives the
// mcu or spi command port and checks responses and LED pins against
// values worked out from the block map. A response monitor queues
// every accepted response so that tests can read them in order.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module processorTb import busPkg::*, blockMapPkg::*;
();

	// Bus holds one, FIFO holds four, selector holds one
	localparam int acceptLimit   = 4 + 2;
	// Well above the summed test length of about 250 cycles
	localparam int timeoutCycles = 2000;

	logic                 sysClk;
	logic                 arstN;
	logic                 masterSel;
	logic                 mcuValid;
	logic                 mcuReady;
	usiOpT                mcuOp;
	blockIdT              mcuBlock;
	logic [csrWidth-1:0]  mcuCsr;
	logic [dataWidth-1:0] mcuWdata;
	logic                 spiValid;
	logic                 spiReady;
	usiOpT                spiOp;
	blockIdT              spiBlock;
	logic [csrWidth-1:0]  spiCsr;
	logic [dataWidth-1:0] spiWdata;
	logic                 rspValid;
	logic                 rspReady;
	logic [dataWidth-1:0] rspData;
	logic                 rspErr;
	logic [1:0]           led;
	logic                 ledB;
	logic                 ledG;
	logic                 ledR;

	logic [dataWidth-1:0] rspDataQ [$];
	logic                 rspErrQ  [$];
	logic [31:0]          rngState;
	logic                 watchMcu;
	logic                 mcuLeak;
	logic                 watchSpi;
	logic                 spiLeak;
	int                   errCount;
	int                   passCount;
	int                   failCount;
	int                   cycleCount;

	processor i_dut (.*);

	always #5 sysClk = ~sysClk;

	// Timeout
	always @(posedge sysClk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount == timeoutCycles)
		begin
			$display("Timeout: no finish within %0d cycles", timeoutCycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// Response monitor samples at the falling edge before each transfer
	always @(negedge sysClk)
	begin
		if (arstN && rspValid && rspReady)
		begin
			rspDataQ.push_back(rspData);
			rspErrQ.push_back(rspErr);
		end
		if (watchMcu && mcuReady)
			mcuLeak = 1'b1;
		if (watchSpi && spiReady)
			spiLeak = 1'b1;
	end

	//----------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextRand(output logic [dataWidth-1:0] word);
		rngState = xorshift32(rngState);
		word = rngState;
	endtask

	task automatic checkData(input string name, input logic [dataWidth-1:0] actual,
		input logic [dataWidth-1:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, got %h", name, expected, actual);
			errCount = errCount + 1;
		end
	endtask

	task automatic checkErr(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, got %h", name, expected, actual);
			errCount = errCount + 1;
		end
	endtask

	// Holds Valid until the selected port takes the command
	task automatic sendCmd(input logic spiPort, input usiOpT op, input blockIdT blk,
		input logic [csrWidth-1:0] csr, input logic [dataWidth-1:0] wdata);
		logic taken;
		taken = 1'b0;
		if (spiPort)
		begin
			spiValid = 1'b1;
			spiOp    = op;
			spiBlock = blk;
			spiCsr   = csr;
			spiWdata = wdata;
		end
		else
		begin
			mcuValid = 1'b1;
			mcuOp    = op;
			mcuBlock = blk;
			mcuCsr   = csr;
			mcuWdata = wdata;
		end
		while (!taken)
		begin
			@(negedge sysClk);
			taken = spiPort ? spiReady : mcuReady;
			@(posedge sysClk);
			#1;
		end
		if (spiPort)
			spiValid = 1'b0;
		else
			mcuValid = 1'b0;
	endtask

	task automatic getRsp(output logic [dataWidth-1:0] data, output logic err);
		while (rspDataQ.size() == 0)
		begin
			@(posedge sysClk);
			#1;
		end
		data = rspDataQ.pop_front();
		err  = rspErrQ.pop_front();
	endtask

	task automatic transact(input logic spiPort, input usiOpT op, input blockIdT blk,
		input logic [csrWidth-1:0] csr, input logic [dataWidth-1:0] wdata,
		input logic [dataWidth-1:0] expData, input logic expErr);
		logic [dataWidth-1:0] data;
		logic                 err;
		sendCmd(spiPort, op, blk, csr, wdata);
		getRsp(data, err);
		checkData("rspData", data, expData);
		checkErr("rspErr", err, expErr);
	endtask

	task automatic endTest(input string name, input int errBefore);
		if (errCount == errBefore)
			passCount = passCount + 1;
		else
			failCount = failCount + 1;
		$display("%s: %s", name, (errCount == errBefore) ? "ok" : "FAILED");
	endtask

	//----------------------------------------------------------------
	// Directed tests
	//----------------------------------------------------------------
	task automatic gpioReadBack();
		int errBefore;
		errBefore = errCount;
		transact(1'b0, usiWrite, blockGpio, gpioLedCsr, 32'h2, 32'h0, 1'b0);
		transact(1'b0, usiWrite, blockGpio, gpioRgbCsr, 32'h5, 32'h0, 1'b0);
		checkData("led", dataWidth'(led), 32'h2);
		checkErr("ledB", ledB, 1'b1);
		checkErr("ledG", ledG, 1'b0);
		checkErr("ledR", ledR, 1'b1);
		transact(1'b0, usiRead, blockGpio, gpioLedCsr, 32'h0, 32'h2, 1'b0);
		transact(1'b0, usiRead, blockGpio, gpioRgbCsr, 32'h0, 32'h5, 1'b0);
		endTest("gpioReadBack", errBefore);
	endtask

	task automatic ramBurst();
		int                   errBefore;
		logic [dataWidth-1:0] words [5];
		errBefore = errCount;
		transact(1'b0, usiWrite, blockRam, ramPtrCsr, 32'd3, 32'h0, 1'b0);
		for (int i = 0; i < 5; i++)
		begin
			nextRand(words[i]);
			transact(1'b0, usiWrite, blockRam, ramDataCsr, words[i], 32'h0, 1'b0);
		end
		transact(1'b0, usiWrite, blockRam, ramPtrCsr, 32'd3, 32'h0, 1'b0);
		for (int i = 0; i < 5; i++)
			transact(1'b0, usiRead, blockRam, ramDataCsr, 32'h0, words[i], 1'b0);
		transact(1'b0, usiRead, blockRam, ramPtrCsr, 32'h0, 32'd8, 1'b0);
		endTest("ramBurst", errBefore);
	endtask

	task automatic masterSwitch();
		int errBefore;
		errBefore = errCount;
		// mcu command waits while spi owns the bus
		masterSel = 1'b1;
		mcuValid  = 1'b1;
		mcuOp     = usiWrite;
		mcuBlock  = blockGpio;
		mcuCsr    = gpioLedCsr;
		mcuWdata  = 32'h1;
		mcuLeak   = 1'b0;
		watchMcu  = 1'b1;
		transact(1'b1, usiWrite, blockGpio, gpioLedCsr, 32'h3, 32'h0, 1'b0);
		transact(1'b1, usiRead, blockGpio, gpioLedCsr, 32'h0, 32'h3, 1'b0);
		watchMcu = 1'b0;
		checkErr("mcuReady", mcuLeak, 1'b0);
		masterSel = 1'b0;
		spiLeak   = 1'b0;
		watchSpi  = 1'b1;
		transact(1'b0, usiWrite, blockGpio, gpioLedCsr, 32'h1, 32'h0, 1'b0);
		watchSpi = 1'b0;
		checkErr("spiReady", spiLeak, 1'b0);
		checkData("led", dataWidth'(led), 32'h1);
		endTest("masterSwitch", errBefore);
	endtask

	task automatic unmappedBlock();
		int errBefore;
		errBefore = errCount;
		transact(1'b0, usiRead, blockIdT'(4'd3), gpioLedCsr, 32'h0, 32'h0, 1'b1);
		transact(1'b0, usiWrite, blockIdT'(4'd3), gpioLedCsr, 32'hff, 32'h0, 1'b1);
		checkData("led", dataWidth'(led), 32'h1);
		checkData("ledRgb", dataWidth'({ledB, ledG, ledR}), 32'h5);
		endTest("unmappedBlock", errBefore);
	endtask

	task automatic backPressure();
		int                   errBefore;
		int                   accepted;
		int                   waitCycles;
		int                   stalledAt;
		logic                 released;
		logic [dataWidth-1:0] words [8];
		logic [dataWidth-1:0] data;
		logic                 err;
		errBefore  = errCount;
		accepted   = 0;
		waitCycles = 0;
		stalledAt  = 8;
		released   = 1'b0;
		for (int i = 0; i < 8; i++)
			nextRand(words[i]);
		transact(1'b0, usiWrite, blockRam, ramPtrCsr, 32'd0, 32'h0, 1'b0);
		rspReady = 1'b0;
		while (accepted < 8)
		begin
			mcuValid = 1'b1;
			mcuOp    = usiWrite;
			mcuBlock = blockRam;
			mcuCsr   = ramDataCsr;
			mcuWdata = words[accepted];
			@(negedge sysClk);
			if (mcuReady)
				accepted = accepted + 1;
			else
				waitCycles = waitCycles + 1;
			// Release responses after a long stall
			if (waitCycles == 10 && !released)
			begin
				stalledAt = accepted;
				released  = 1'b1;
			end
			@(posedge sysClk);
			#1;
			if (released)
				rspReady = 1'b1;
		end
		mcuValid = 1'b0;
		rspReady = 1'b1;
		checkData("acceptedBeforeStall", dataWidth'(stalledAt), dataWidth'(acceptLimit));
		for (int i = 0; i < 8; i++)
		begin
			getRsp(data, err);
			checkData("rspData", data, 32'h0);
			checkErr("rspErr", err, 1'b0);
		end
		transact(1'b0, usiWrite, blockRam, ramPtrCsr, 32'd0, 32'h0, 1'b0);
		for (int i = 0; i < 8; i++)
			transact(1'b0, usiRead, blockRam, ramDataCsr, 32'h0, words[i], 1'b0);
		endTest("backPressure", errBefore);
	endtask

	//----------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------
	initial
	begin
		sysClk     = 1'b0;
		arstN      = 1'b0;
		masterSel  = 1'b0;
		mcuValid   = 1'b0;
		mcuOp      = usiRead;
		mcuBlock   = blockGpio;
		mcuCsr     = '0;
		mcuWdata   = '0;
		spiValid   = 1'b0;
		spiOp      = usiRead;
		spiBlock   = blockGpio;
		spiCsr     = '0;
		spiWdata   = '0;
		rspReady   = 1'b0;
		rngState   = 32'h42185d7d;
		watchMcu   = 1'b0;
		mcuLeak    = 1'b0;
		watchSpi   = 1'b0;
		spiLeak    = 1'b0;
		errCount   = 0;
		passCount  = 0;
		failCount  = 0;
		cycleCount = 0;
		repeat (5) @(posedge sysClk);
		#1;
		arstN    = 1'b1;
		rspReady = 1'b1;
		gpioReadBack();
		ramBurst();
		masterSwitch();
		unmappedBlock();
		backPressure();
		$display("Summary: %0d passed, %0d failed, %0d check errors",
			passCount, failCount, errCount);
		if (failCount == 0 && errCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: dv/processor_sva.sv
//--------------------------------------------------------------------
// Concurrent assertions for the register-bus core, bound into the
// processor top. Covers the response hold rule, master Ready during
// reset, strobe to response timing and the response port after reset.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module processorSva import busPkg::*;
(
	input logic                 sysClk,
	input logic                 arstN,
	input logic                 mcuReady,
	input logic                 spiReady,
	input logic                 csrWrite,
	input logic                 csrRead,
	input logic                 rspValid,
	input logic                 rspReady,
	input logic [dataWidth-1:0] rspData
);

	// Response held under back-pressure
	aRspHold: assert property (@(posedge sysClk) disable iff (!arstN)
		rspValid && !rspReady |=> rspValid && $stable(rspData))
		else $error("rspValid or rspData changed while rspReady was low");

	// Masters held off through reset and the first edge after it
	aReadyInReset: assert property (@(posedge sysClk)
		(!arstN || $rose(arstN)) |-> !mcuReady && !spiReady)
		else $error("mcuReady or spiReady high during reset");

	// Strobe in usiAccess, response two cycles later in usiRespond
	aStrobeRsp: assert property (@(posedge sysClk) disable iff (!arstN)
		$past(csrWrite || csrRead, 2) |-> rspValid)
		else $error("Slave strobe not answered two cycles later");

	// First edge after reset release
	aRspAfterReset: assert property (@(posedge sysClk)
		$rose(arstN) |-> !rspValid)
		else $error("rspValid high right after reset release");

endmodule

bind processor processorSva sva (.*);

// File: run.sh
#!/usr/bin/env bash
# Compile and run the register-bus testbench with Verilator.
# Exits nonzero when the build fails, the run fails or the log reports failure.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module processorTb -o processorTbSim \
	&& ./obj_dir/processorTbSim > sim.log 2>&1 \
	|| { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || grep -q "All tests passed" sim.log

// File: sources.f
src/busPkg.sv
src/blockMapPkg.sv
src/usiMasterSelect.sv
src/usiCmdFifo.sv
src/usiBus.sv
src/gpioBlock.sv
src/ramBlock.sv
src/processor.sv
dv/processor_sva.sv
dv/processorTb.sv

// File: src/blockMapPkg.sv
//--------------------------------------------------------------------
// Block address map of the register bus and the CSR offsets inside
// each slave block. Block numbers follow the original processor map,
// so only GPIO and RAM remain and every other number is unmapped.
//--------------------------------------------------------------------
package blockMapPkg;

	import busPkg::*;

	//----------------------------------------------------------------
	// Block numbers
	//----------------------------------------------------------------
	typedef enum logic [blockWidth-1:0]
	{
		blockGpio = 4'd1,
		blockRam  = 4'd6
	} blockIdT;

	//----------------------------------------------------------------
	// GPIO block CSRs
	//----------------------------------------------------------------
	// Two LED pins
	localparam logic [csrWidth-1:0] gpioLedCsr = 8'd0;
	// Blue, green, red at bits 2..0
	localparam logic [csrWidth-1:0] gpioRgbCsr = 8'd1;

	//----------------------------------------------------------------
	// RAM block CSRs
	//----------------------------------------------------------------
	localparam logic [csrWidth-1:0] ramPtrCsr  = 8'd0;
	localparam logic [csrWidth-1:0] ramDataCsr = 8'd1;

endpackage

// File: src/busPkg.sv
//--------------------------------------------------------------------
// Register bus format shared by the selector, FIFO and sequencer.
// Holds the field widths, the command opcode and the states of the
// bus sequencer, so that the assertion module can name them too.
//--------------------------------------------------------------------
package busPkg;

	//----------------------------------------------------------------
	// Field widths
	//----------------------------------------------------------------
	localparam int dataWidth  = 32;
	localparam int blockWidth = 4;
	localparam int csrWidth   = 8;

	// Command opcode
	typedef enum logic
	{
		usiRead  = 1'b0,
		usiWrite = 1'b1
	} usiOpT;

	// Sequencer states, one command per pass
	typedef enum logic [1:0]
	{
		usiIdle    = 2'd0,
		usiAccess  = 2'd1,
		usiCapture = 2'd2,
		usiRespond = 2'd3
	} usiStateT;

endpackage

// File: src/gpioBlock.sv
//--------------------------------------------------------------------
// GPIO slave with the LED and RGB control registers. The registers
// drive the pins directly and read back one cycle after csrRead.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module gpioBlock import busPkg::*, blockMapPkg::*;
(
	input  logic                 sysClk,
	input  logic                 arstN,
	input  logic                 gpioSel,
	input  logic                 csrWrite,
	input  logic                 csrRead,
	input  logic [csrWidth-1:0]  csrAddr,
	input  logic [dataWidth-1:0] csrWdata,
	output logic [dataWidth-1:0] gpioRdata,
	output logic [1:0]           led,
	output logic                 ledB,
	output logic                 ledG,
	output logic                 ledR
);

	logic [1:0] ledReg;
	logic [2:0] rgbReg;

	assign led  = ledReg;
	assign ledB = rgbReg[2];
	assign ledG = rgbReg[1];
	assign ledR = rgbReg[0];

	// Writes to unknown offsets fall through
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			ledReg <= '0;
			rgbReg <= '0;
		end
		else if (gpioSel && csrWrite)
		begin
			case (csrAddr)
				gpioLedCsr: ledReg <= csrWdata[1:0];
				gpioRgbCsr: rgbReg <= csrWdata[2:0];
				default:    ;
			endcase
		end
	end

	// Read-back
	always_ff @(posedge sysClk)
	begin
		if (gpioSel && csrRead)
		begin
			case (csrAddr)
				gpioLedCsr: gpioRdata <= dataWidth'(ledReg);
				gpioRgbCsr: gpioRdata <= dataWidth'(rgbReg);
				default:    gpioRdata <= '0;
			endcase
		end
	end

endmodule

// File: src/processor.sv
//--------------------------------------------------------------------
// Register-bus core of the processor. Two command masters share one
// bus through the master selector and the command FIFO; the bus
// sequencer serves the GPIO and RAM blocks and returns responses in
// command order. Sizes of the FIFO and the RAM are set here.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module processor import busPkg::*, blockMapPkg::*;
#(
	parameter int fifoDepth = 4,
	parameter int ramDepth  = 16
)(
	input  logic                 sysClk,
	input  logic                 arstN,
	input  logic                 masterSel,
	// mcu command port
	input  logic                 mcuValid,
	output logic                 mcuReady,
	input  usiOpT                mcuOp,
	input  blockIdT              mcuBlock,
	input  logic [csrWidth-1:0]  mcuCsr,
	input  logic [dataWidth-1:0] mcuWdata,
	// spi command port
	input  logic                 spiValid,
	output logic                 spiReady,
	input  usiOpT                spiOp,
	input  blockIdT              spiBlock,
	input  logic [csrWidth-1:0]  spiCsr,
	input  logic [dataWidth-1:0] spiWdata,
	// Response port
	output logic                 rspValid,
	input  logic                 rspReady,
	output logic [dataWidth-1:0] rspData,
	output logic                 rspErr,
	// LED pins
	output logic [1:0]           led,
	output logic                 ledB,
	output logic                 ledG,
	output logic                 ledR
);

	//----------------------------------------------------------------
	// Selector to FIFO
	//----------------------------------------------------------------
	logic                 cmdValid;
	logic                 cmdReady;
	usiOpT                cmdOp;
	blockIdT              cmdBlock;
	logic [csrWidth-1:0]  cmdCsr;
	logic [dataWidth-1:0] cmdWdata;

	//----------------------------------------------------------------
	// FIFO to sequencer
	//----------------------------------------------------------------
	logic                 pop;
	logic                 popValid;
	usiOpT                headOp;
	blockIdT              headBlock;
	logic [csrWidth-1:0]  headCsr;
	logic [dataWidth-1:0] headWdata;

	//----------------------------------------------------------------
	// Sequencer to slaves
	//----------------------------------------------------------------
	logic                 gpioSel;
	logic                 ramSel;
	logic                 csrWrite;
	logic                 csrRead;
	logic [csrWidth-1:0]  csrAddr;
	logic [dataWidth-1:0] csrWdata;
	logic [dataWidth-1:0] gpioRdata;
	logic [dataWidth-1:0] ramRdata;

	// Ports connect by name to the wires above
	usiMasterSelect usiMasterSelect (.*);

	usiCmdFifo #(
		.fifoDepth (fifoDepth)
	) usiCmdFifo (.*);

	usiBus usiBus (.*);

	gpioBlock gpioBlock (.*);

	ramBlock #(
		.ramDepth (ramDepth)
	) ramBlock (.*);

endmodule

// File: src/ramBlock.sv
//--------------------------------------------------------------------
// Internal memory slave reached through two CSRs. A pointer register
// selects the word and the data window reads or writes it, then steps
// the pointer, so a run of data accesses walks the memory in order.
// ramDepth must be a power of two so the pointer wraps by itself.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module ramBlock import busPkg::*, blockMapPkg::*;
#(
	parameter int ramDepth = 16
)(
	input  logic                 sysClk,
	input  logic                 arstN,
	input  logic                 ramSel,
	input  logic                 csrWrite,
	input  logic                 csrRead,
	input  logic [csrWidth-1:0]  csrAddr,
	input  logic [dataWidth-1:0] csrWdata,
	output logic [dataWidth-1:0] ramRdata
);

	localparam int ptrWidth = $clog2(ramDepth);

	logic [dataWidth-1:0] mem [ramDepth];
	logic [ptrWidth-1:0]  ptr;
	logic                 wrAccess;
	logic                 rdAccess;

	assign wrAccess = ramSel && csrWrite;
	assign rdAccess = ramSel && csrRead;

	//----------------------------------------------------------------
	// Pointer
	//----------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			ptr <= '0;
		else if (wrAccess && csrAddr == ramPtrCsr)
			ptr <= csrWdata[ptrWidth-1:0];
		else if ((wrAccess || rdAccess) && csrAddr == ramDataCsr)
			ptr <= ptr + 1'b1;
	end

	//----------------------------------------------------------------
	// Memory and read port
	//----------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (wrAccess && csrAddr == ramDataCsr)
			mem[ptr] <= csrWdata;
	end

	always_ff @(posedge sysClk)
	begin
		if (rdAccess)
		begin
			case (csrAddr)
				ramPtrCsr:  ramRdata <= dataWidth'(ptr);
				ramDataCsr: ramRdata <= mem[ptr];
				default:    ramRdata <= '0;
			endcase
		end
	end

endmodule

// File: src/usiBus.sv
//--------------------------------------------------------------------
// Register bus sequencer. Takes one command from the FIFO head,
// decodes its block number, strobes the selected slave for a cycle
// and returns one response per command on a valid/ready port.
// Unmapped blocks get no strobe and answer with the error flag.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module usiBus import busPkg::*, blockMapPkg::*;
(
	input  logic                 sysClk,
	input  logic                 arstN,
	// FIFO head
	input  logic                 popValid,
	output logic                 pop,
	input  usiOpT                headOp,
	input  blockIdT              headBlock,
	input  logic [csrWidth-1:0]  headCsr,
	input  logic [dataWidth-1:0] headWdata,
	// Slave side
	output logic                 gpioSel,
	output logic                 ramSel,
	output logic                 csrWrite,
	output logic                 csrRead,
	output logic [csrWidth-1:0]  csrAddr,
	output logic [dataWidth-1:0] csrWdata,
	input  logic [dataWidth-1:0] gpioRdata,
	input  logic [dataWidth-1:0] ramRdata,
	// Response port
	output logic                 rspValid,
	input  logic                 rspReady,
	output logic [dataWidth-1:0] rspData,
	output logic                 rspErr
);

	usiStateT             state;
	usiStateT             nextState;
	usiOpT                curOp;
	logic                 gpioHit;
	logic                 ramHit;
	logic [csrWidth-1:0]  curCsr;
	logic [dataWidth-1:0] curWdata;

	assign pop      = (state == usiIdle) && popValid;
	assign gpioSel  = gpioHit;
	assign ramSel   = ramHit;
	assign csrAddr  = curCsr;
	assign csrWdata = curWdata;
	assign rspValid = (state == usiRespond);

	// One strobe per mapped command, in usiAccess only
	assign csrWrite = (state == usiAccess) && (gpioHit || ramHit) && (curOp == usiWrite);
	assign csrRead  = (state == usiAccess) && (gpioHit || ramHit) && (curOp == usiRead);

	always_comb
	begin
		nextState = state;
		case (state)
			usiIdle:    if (popValid) nextState = usiAccess;
			usiAccess:  nextState = usiCapture;
			usiCapture: nextState = usiRespond;
			// Hold the response until the consumer takes it
			usiRespond: if (rspReady) nextState = usiIdle;
			default:    nextState = usiIdle;
		endcase
	end

	//----------------------------------------------------------------
	// State and block decode
	//----------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= usiIdle;
			curOp   <= usiRead;
			gpioHit <= 1'b0;
			ramHit  <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (pop)
			begin
				curOp   <= headOp;
				gpioHit <= 1'b0;
				ramHit  <= 1'b0;
				case (headBlock)
					blockGpio: gpioHit <= 1'b1;
					blockRam:  ramHit  <= 1'b1;
					default:   ;
				endcase
			end
		end
	end

	//----------------------------------------------------------------
	// Command payload and response
	//----------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (pop)
		begin
			curCsr   <= headCsr;
			curWdata <= headWdata;
		end
		// Slave read data is valid one cycle after the strobe
		if (state == usiCapture)
		begin
			rspErr <= !(gpioHit || ramHit);
			if (curOp == usiRead && gpioHit)
				rspData <= gpioRdata;
			else if (curOp == usiRead && ramHit)
				rspData <= ramRdata;
			else
				rspData <= '0;
		end
	end

endmodule

// File: src/usiCmdFifo.sv
//--------------------------------------------------------------------
// Circular command buffer between the master selector and the bus
// sequencer. Pushes on cmdValid with cmdReady, pops on pop. The head
// entry is read combinationally, so a push shows one cycle later.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module usiCmdFifo import busPkg::*, blockMapPkg::*;
#(
	parameter int fifoDepth = 4
)(
	input  logic                 sysClk,
	input  logic                 arstN,
	input  logic                 cmdValid,
	output logic                 cmdReady,
	input  usiOpT                cmdOp,
	input  blockIdT              cmdBlock,
	input  logic [csrWidth-1:0]  cmdCsr,
	input  logic [dataWidth-1:0] cmdWdata,
	input  logic                 pop,
	output logic                 popValid,
	output usiOpT                headOp,
	output blockIdT              headBlock,
	output logic [csrWidth-1:0]  headCsr,
	output logic [dataWidth-1:0] headWdata
);

	localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int cntWidth = $clog2(fifoDepth + 1);

	usiOpT                opMem    [fifoDepth];
	blockIdT              blockMem [fifoDepth];
	logic [csrWidth-1:0]  csrMem   [fifoDepth];
	logic [dataWidth-1:0] dataMem  [fifoDepth];
	logic [ptrWidth-1:0]  wrPtr;
	logic [ptrWidth-1:0]  rdPtr;
	logic [cntWidth-1:0]  count;
	logic                 push;
	logic                 popEn;

	// Wrap at fifoDepth, which need not be a power of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(fifoDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign cmdReady  = (count != cntWidth'(fifoDepth));
	assign popValid  = (count != '0);
	assign push      = cmdValid && cmdReady;
	assign popEn     = pop && popValid;
	assign headOp    = opMem[rdPtr];
	assign headBlock = blockMem[rdPtr];
	assign headCsr   = csrMem[rdPtr];
	assign headWdata = dataMem[rdPtr];

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (popEn)
				rdPtr <= nextPtr(rdPtr);
			case ({push, popEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge sysClk)
	begin
		if (push)
		begin
			opMem[wrPtr]    <= cmdOp;
			blockMem[wrPtr] <= cmdBlock;
			csrMem[wrPtr]   <= cmdCsr;
			dataMem[wrPtr]  <= cmdWdata;
		end
	end

endmodule

// File: src/usiMasterSelect.sv
//--------------------------------------------------------------------
// Picks the mcu or spi command port with masterSel and registers the
// accepted command in a one-entry stage in front of the command FIFO.
// Only the named master sees Ready, and only while the stage is free
// or is being drained by the FIFO in the same cycle.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module usiMasterSelect import busPkg::*, blockMapPkg::*;
(
	input  logic                 sysClk,
	input  logic                 arstN,
	input  logic                 masterSel,
	// mcu port
	input  logic                 mcuValid,
	output logic                 mcuReady,
	input  usiOpT                mcuOp,
	input  blockIdT              mcuBlock,
	input  logic [csrWidth-1:0]  mcuCsr,
	input  logic [dataWidth-1:0] mcuWdata,
	// spi port
	input  logic                 spiValid,
	output logic                 spiReady,
	input  usiOpT                spiOp,
	input  blockIdT              spiBlock,
	input  logic [csrWidth-1:0]  spiCsr,
	input  logic [dataWidth-1:0] spiWdata,
	// Toward the FIFO
	output logic                 cmdValid,
	input  logic                 cmdReady,
	output usiOpT                cmdOp,
	output blockIdT              cmdBlock,
	output logic [csrWidth-1:0]  cmdCsr,
	output logic [dataWidth-1:0] cmdWdata
);

	logic active;
	logic canAccept;
	logic mcuFire;
	logic spiFire;

	// Stage is free, or the FIFO takes its entry this cycle
	assign canAccept = active && (!cmdValid || cmdReady);
	assign mcuReady  = canAccept && !masterSel;
	assign spiReady  = canAccept && masterSel;
	assign mcuFire   = mcuValid && mcuReady;
	assign spiFire   = spiValid && spiReady;

	// Masters are held off until the first clock after reset
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			active   <= 1'b0;
			cmdValid <= 1'b0;
		end
		else
		begin
			active <= 1'b1;
			if (mcuFire || spiFire)
				cmdValid <= 1'b1;
			else if (cmdReady)
				cmdValid <= 1'b0;
		end
	end

	always_ff @(posedge sysClk)
	begin
		if (mcuFire)
		begin
			cmdOp    <= mcuOp;
			cmdBlock <= mcuBlock;
			cmdCsr   <= mcuCsr;
			cmdWdata <= mcuWdata;
		end
		else if (spiFire)
		begin
			cmdOp    <= spiOp;
			cmdBlock <= spiBlock;
			cmdCsr   <= spiCsr;
			cmdWdata <= spiWdata;
		end
	end

endmodule
